/* sources.f */
design/procyon_biu_pkg.sv
design/procyon_biu_req_if.sv
design/procyon_wb_if.sv
design/procyon_biu_arbiter.sv
design/procyon_biu_controller_wb.sv
design/procyon_wb_sram.sv
design/procyon_biu.sv
dv/procyon_biu_tb.sv

/* Bender.yml */
package:
  name: procyon_biu

sources:
  - files:
      - design/procyon_biu_pkg.sv
      - design/procyon_biu_req_if.sv
      - design/procyon_wb_if.sv
      - design/procyon_biu_arbiter.sv
      - design/procyon_biu_controller_wb.sv
      - design/procyon_wb_sram.sv
      - design/procyon_biu.sv
  - target: test
    files:
      - dv/procyon_biu_tb.sv

/* dv/procyon_biu_tb.sv */
//////////////////////////////
// Directed testbench for the BIU top
// RAM starts unknown and every read
// targets bytes written earlier
// All addresses are word aligned
//////////////////////////////

module procyon_biu_tb;

    localparam BIU_DATA_SIZE  = procyon_biu_pkg::BIU_LEN_MAX_SIZE;
    localparam WB_DATA_WIDTH  = 16;
    localparam RAM_DEPTH      = 64;
    localparam WORD_BYTES     = WB_DATA_WIDTH / 8;
    localparam RAM_BYTES      = RAM_DEPTH * WORD_BYTES;
    localparam LINE_WIDTH     = BIU_DATA_SIZE * 8;
    // About 25 requests of under 30 cycles each
    localparam TIMEOUT_CYCLES = 2000;

    logic                       clk;
    logic                       rst;
    logic                       en [2];
    procyon_biu_pkg::biu_func_e func [2];
    procyon_biu_pkg::biu_len_e  len [2];
    logic [BIU_DATA_SIZE-1:0]   sel [2];
    logic [31:0]                addr [2];
    logic [LINE_WIDTH-1:0]      wdata [2];
    logic                       done [2];
    logic [LINE_WIDTH-1:0]      rdata [2];
    logic [7:0]                 shadow [0:RAM_BYTES-1];
    logic [31:0]                rng_state;
    int                         cycle_count;
    int                         done_count [2];
    int                         done_cycle [2];

    procyon_biu #(
        .OPTN_BIU_DATA_SIZE(BIU_DATA_SIZE),
        .OPTN_WB_DATA_WIDTH(WB_DATA_WIDTH),
        .OPTN_ADDR_WIDTH(32),
        .OPTN_RAM_DEPTH(RAM_DEPTH)
    ) dut (
        .i_wb_clk(clk),
        .i_rst(rst),
        .i_p0_en(en[0]),
        .i_p0_func(func[0]),
        .i_p0_len(len[0]),
        .i_p0_sel(sel[0]),
        .i_p0_addr(addr[0]),
        .i_p0_data(wdata[0]),
        .o_p0_done(done[0]),
        .o_p0_data(rdata[0]),
        .i_p1_en(en[1]),
        .i_p1_func(func[1]),
        .i_p1_len(len[1]),
        .i_p1_sel(sel[1]),
        .i_p1_addr(addr[1]),
        .i_p1_data(wdata[1]),
        .o_p1_done(done[1]),
        .o_p1_data(rdata[1])
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input logic [LINE_WIDTH-1:0] actual,
                         input logic [LINE_WIDTH-1:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    // Done pulses counted mid cycle where outputs are settled
    always @(negedge clk) begin
        cycle_count++;
        for (int p = 0; p < 2; p++) begin
            if (done[p]) begin
                done_count[p]++;
                done_cycle[p] = cycle_count;
            end
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: a request did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_line(output logic [LINE_WIDTH-1:0] line);
        for (int i = 0; i < LINE_WIDTH / 32; i++) begin
            rng_state = xorshift32(rng_state);
            line[i*32 +: 32] = rng_state;
        end
    endtask

    // Bytes touched by a request never fall below one bus word
    function automatic int touched_bytes(input procyon_biu_pkg::biu_len_e l);
        int n;
        case (l)
            procyon_biu_pkg::BIU_LEN_1B: n = 1;
            procyon_biu_pkg::BIU_LEN_2B: n = 2;
            procyon_biu_pkg::BIU_LEN_4B: n = 4;
            procyon_biu_pkg::BIU_LEN_8B: n = 8;
            default: n = 16;
        endcase
        return (n < WORD_BYTES) ? WORD_BYTES : n;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] expected_line(input logic [31:0] a,
                                                            input procyon_biu_pkg::biu_len_e l);
        logic [LINE_WIDTH-1:0] line;
        line = '0;
        for (int i = 0; i < touched_bytes(l); i++) begin
            line[i*8 +: 8] = shadow[(a + i) % RAM_BYTES];
        end
        return line;
    endfunction

    task automatic shadow_write(input logic [31:0] a, input procyon_biu_pkg::biu_len_e l,
                                input logic [BIU_DATA_SIZE-1:0] s, input logic [LINE_WIDTH-1:0] d);
        for (int i = 0; i < touched_bytes(l); i++) begin
            if (s[i]) begin
                shadow[(a + i) % RAM_BYTES] = d[i*8 +: 8];
            end
        end
    endtask

    // Holds the request until done and then leaves en low for one edge
    task automatic do_request(input int p, input procyon_biu_pkg::biu_func_e f,
                              input procyon_biu_pkg::biu_len_e l,
                              input logic [BIU_DATA_SIZE-1:0] s,
                              input logic [31:0] a, input logic [LINE_WIDTH-1:0] d,
                              output logic [LINE_WIDTH-1:0] result);
        logic seen;
        func[p]  = f;
        len[p]   = l;
        sel[p]   = s;
        addr[p]  = a;
        wdata[p] = d;
        en[p]    = 1'b1;
        seen     = 1'b0;
        while (!seen) begin
            @(posedge clk);
            #1;
            seen = done[p];
        end
        result = rdata[p];
        en[p]  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic write_req(input int p, input procyon_biu_pkg::biu_len_e l,
                             input logic [BIU_DATA_SIZE-1:0] s, input logic [31:0] a,
                             input logic [LINE_WIDTH-1:0] d);
        logic [LINE_WIDTH-1:0] unused;
        do_request(p, procyon_biu_pkg::BIU_FUNC_WRITE, l, s, a, d, unused);
        shadow_write(a, l, s, d);
    endtask

    task automatic read_check(input int p, input procyon_biu_pkg::biu_len_e l,
                              input logic [31:0] a, input string what,
                              output logic [LINE_WIDTH-1:0] result);
        do_request(p, procyon_biu_pkg::BIU_FUNC_READ, l, '1, a, '0, result);
        check(result, expected_line(a, l), what);
    endtask

    task automatic test_idle_and_word();
        logic [LINE_WIDTH-1:0] d;
        logic [LINE_WIDTH-1:0] r;
        repeat (5) begin
            @(posedge clk);
            #1;
            check(done[0] | done[1], 1'b0, "done high with no request");
        end
        next_line(d);
        write_req(0, procyon_biu_pkg::BIU_LEN_2B, 16'h0003, 32'h00, d);
        do_request(0, procyon_biu_pkg::BIU_FUNC_READ, procyon_biu_pkg::BIU_LEN_2B, '1,
                   32'h00, '0, r);
        check(r[LINE_WIDTH-1:16], '0, "upper words of 2B read");
        check(r, expected_line(32'h00, procyon_biu_pkg::BIU_LEN_2B), "2B read");
    endtask

    task automatic test_full_line();
        logic [LINE_WIDTH-1:0] d;
        logic [LINE_WIDTH-1:0] r;
        next_line(d);
        write_req(0, procyon_biu_pkg::BIU_LEN_16B, '1, 32'h10, d);
        read_check(0, procyon_biu_pkg::BIU_LEN_16B, 32'h10, "16B burst read", r);
    endtask

    task automatic test_partial_write();
        logic [LINE_WIDTH-1:0] d;
        logic [LINE_WIDTH-1:0] r;
        next_line(d);
        write_req(1, procyon_biu_pkg::BIU_LEN_16B, '1, 32'h20, d);
        next_line(d);
        write_req(1, procyon_biu_pkg::BIU_LEN_16B, 16'h0f3c, 32'h20, d);
        read_check(1, procyon_biu_pkg::BIU_LEN_16B, 32'h20, "read after partial write", r);
    endtask

    task automatic test_rmw();
        logic [LINE_WIDTH-1:0] d;
        logic [LINE_WIDTH-1:0] old;
        logic [LINE_WIDTH-1:0] r;
        next_line(d);
        write_req(0, procyon_biu_pkg::BIU_LEN_16B, '1, 32'h30, d);
        old = expected_line(32'h30, procyon_biu_pkg::BIU_LEN_8B);
        next_line(d);
        do_request(0, procyon_biu_pkg::BIU_FUNC_RMW, procyon_biu_pkg::BIU_LEN_8B, 16'h00a5,
                   32'h30, d, r);
        check(r, old, "RMW returned data");
        shadow_write(32'h30, procyon_biu_pkg::BIU_LEN_8B, 16'h00a5, d);
        read_check(0, procyon_biu_pkg::BIU_LEN_16B, 32'h30, "read after RMW", r);
    endtask

    task automatic test_contention();
        logic [LINE_WIDTH-1:0] d;
        logic [LINE_WIDTH-1:0] r0;
        logic [LINE_WIDTH-1:0] r1;
        int c0;
        int c1;
        next_line(d);
        write_req(0, procyon_biu_pkg::BIU_LEN_16B, '1, 32'h40, d);
        // Last write on p1 leaves p0 with priority
        next_line(d);
        write_req(1, procyon_biu_pkg::BIU_LEN_16B, '1, 32'h50, d);
        c0 = done_count[0];
        c1 = done_count[1];
        fork
            do_request(0, procyon_biu_pkg::BIU_FUNC_READ, procyon_biu_pkg::BIU_LEN_16B, '1,
                       32'h40, '0, r0);
            do_request(1, procyon_biu_pkg::BIU_FUNC_READ, procyon_biu_pkg::BIU_LEN_16B, '1,
                       32'h50, '0, r1);
        join
        repeat (4) @(posedge clk);
        #1;
        check(done_count[0] - c0, 1, "p0 done pulses");
        check(done_count[1] - c1, 1, "p1 done pulses");
        check(done_cycle[1] > done_cycle[0], 1'b1, "p1 done after p0 done");
        check(r0, expected_line(32'h40, procyon_biu_pkg::BIU_LEN_16B), "p0 contended read");
        check(r1, expected_line(32'h50, procyon_biu_pkg::BIU_LEN_16B), "p1 contended read");
    endtask

    task automatic test_back_to_back();
        logic [LINE_WIDTH-1:0] d;
        logic [LINE_WIDTH-1:0] r;
        for (int k = 0; k < 4; k++) begin
            next_line(d);
            write_req(1, procyon_biu_pkg::BIU_LEN_4B, '1, 32'h60 + 4 * k, d);
        end
        for (int k = 0; k < 4; k++) begin
            read_check(1, procyon_biu_pkg::BIU_LEN_4B, 32'h60 + 4 * k, "back-to-back read", r);
        end
        read_check(1, procyon_biu_pkg::BIU_LEN_16B, 32'h60, "line after back-to-back", r);
    endtask

    initial begin
        rng_state   = 32'h9ee8f9ab;
        cycle_count = 0;
        rst         = 1'b1;
        for (int p = 0; p < 2; p++) begin
            en[p]         = 1'b0;
            func[p]       = procyon_biu_pkg::BIU_FUNC_READ;
            len[p]        = procyon_biu_pkg::BIU_LEN_1B;
            sel[p]        = '0;
            addr[p]       = '0;
            wdata[p]      = '0;
            done_count[p] = 0;
            done_cycle[p] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_idle_and_word();
        test_full_line();
        test_partial_write();
        test_rmw();
        test_contention();
        test_back_to_back();
        $display("Test passed");
        $finish;
    end

endmodule

/* design/procyon_biu.sv */
//////////////////////////////
// BIU top with two requester ports
// RAM slave is internal, no external bus
// p0 wins the first simultaneous request
//////////////////////////////

module procyon_biu #(
    parameter OPTN_BIU_DATA_SIZE = 16,
    parameter OPTN_WB_DATA_WIDTH = 16,
    parameter OPTN_ADDR_WIDTH    = 32,
    parameter OPTN_RAM_DEPTH     = 64,
    parameter BIU_DATA_WIDTH     = OPTN_BIU_DATA_SIZE * 8
)(
    input  logic                          i_wb_clk,
    input  logic                          i_rst,

    input  logic                          i_p0_en,
    input  procyon_biu_pkg::biu_func_e    i_p0_func,
    input  procyon_biu_pkg::biu_len_e     i_p0_len,
    input  logic [OPTN_BIU_DATA_SIZE-1:0] i_p0_sel,
    input  logic [OPTN_ADDR_WIDTH-1:0]    i_p0_addr,
    input  logic [BIU_DATA_WIDTH-1:0]     i_p0_data,
    output logic                          o_p0_done,
    output logic [BIU_DATA_WIDTH-1:0]     o_p0_data,

    input  logic                          i_p1_en,
    input  procyon_biu_pkg::biu_func_e    i_p1_func,
    input  procyon_biu_pkg::biu_len_e     i_p1_len,
    input  logic [OPTN_BIU_DATA_SIZE-1:0] i_p1_sel,
    input  logic [OPTN_ADDR_WIDTH-1:0]    i_p1_addr,
    input  logic [BIU_DATA_WIDTH-1:0]     i_p1_data,
    output logic                          o_p1_done,
    output logic [BIU_DATA_WIDTH-1:0]     o_p1_data
);

    procyon_biu_req_if #(
        .OPTN_BIU_DATA_SIZE(OPTN_BIU_DATA_SIZE),
        .OPTN_ADDR_WIDTH(OPTN_ADDR_WIDTH)
    ) p0_req (), p1_req (), ctrl_req ();

    procyon_wb_if #(
        .OPTN_WB_DATA_WIDTH(OPTN_WB_DATA_WIDTH),
        .OPTN_ADDR_WIDTH(OPTN_ADDR_WIDTH)
    ) wb_bus ();

    assign p0_req.en    = i_p0_en;
    assign p0_req.func  = i_p0_func;
    assign p0_req.len   = i_p0_len;
    assign p0_req.sel   = i_p0_sel;
    assign p0_req.addr  = i_p0_addr;
    assign p0_req.wdata = i_p0_data;
    assign o_p0_done    = p0_req.done;
    assign o_p0_data    = p0_req.rdata;

    assign p1_req.en    = i_p1_en;
    assign p1_req.func  = i_p1_func;
    assign p1_req.len   = i_p1_len;
    assign p1_req.sel   = i_p1_sel;
    assign p1_req.addr  = i_p1_addr;
    assign p1_req.wdata = i_p1_data;
    assign o_p1_done    = p1_req.done;
    assign o_p1_data    = p1_req.rdata;

    procyon_biu_arbiter biu_arbiter (
        .i_wb_clk(i_wb_clk),
        .i_rst(i_rst),
        .i_p0(p0_req.controller),
        .i_p1(p1_req.controller),
        .o_req(ctrl_req.requester)
    );

    procyon_biu_controller_wb #(
        .OPTN_BIU_DATA_SIZE(OPTN_BIU_DATA_SIZE),
        .OPTN_WB_DATA_WIDTH(OPTN_WB_DATA_WIDTH),
        .OPTN_ADDR_WIDTH(OPTN_ADDR_WIDTH)
    ) biu_controller (
        .i_wb_clk(i_wb_clk),
        .i_rst(i_rst),
        .i_req(ctrl_req.controller),
        .o_wb(wb_bus.master)
    );

    procyon_wb_sram #(
        .OPTN_WB_DATA_WIDTH(OPTN_WB_DATA_WIDTH),
        .OPTN_RAM_DEPTH(OPTN_RAM_DEPTH)
    ) wb_sram (
        .i_wb_clk(i_wb_clk),
        .i_rst(i_rst),
        .i_wb(wb_bus.slave)
    );

endmodule

/* design/procyon_wb_sram.sv */
//////////////////////////////
// Wishbone RAM slave, registered ack
// Word addressed, wraps at the depth
// Bursts run from an internal counter
//////////////////////////////

module procyon_wb_sram #(
    parameter OPTN_WB_DATA_WIDTH = 16,
    parameter OPTN_RAM_DEPTH     = 64
)(
    input  logic          i_wb_clk,
    input  logic          i_rst,
    procyon_wb_if.slave   i_wb
);

    localparam WB_DATA_SIZE   = OPTN_WB_DATA_WIDTH / 8;
    localparam WORD_OFFSET    = $clog2(WB_DATA_SIZE);
    localparam RAM_ADDR_WIDTH = $clog2(OPTN_RAM_DEPTH);

    logic [OPTN_WB_DATA_WIDTH-1:0] mem [0:OPTN_RAM_DEPTH-1];
    logic [OPTN_WB_DATA_WIDTH-1:0] dat_r_r;
    logic [RAM_ADDR_WIDTH-1:0]     start_addr;
    logic [RAM_ADDR_WIDTH-1:0]     beat_addr_r;
    logic [RAM_ADDR_WIDTH-1:0]     next_addr;
    logic                          burst_more;
    logic                          ack_r;

    assign start_addr = i_wb.addr[WORD_OFFSET +: RAM_ADDR_WIDTH];
    assign next_addr  = beat_addr_r + 1'b1;
    assign burst_more = (i_wb.cti == procyon_biu_pkg::WB_CTI_INCREMENTING) &&
                        (i_wb.bte == procyon_biu_pkg::WB_BTE_LINEAR);

    // First stb gets an ack next cycle, a burst keeps ack up
    always_ff @(posedge i_wb_clk) begin
        if (i_rst) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= i_wb.cyc & i_wb.stb & (~ack_r | burst_more);
        end
    end

    // Writes land on the completing edge, reads are fetched a cycle ahead
    always_ff @(posedge i_wb_clk) begin
        if (i_wb.cyc && i_wb.stb) begin
            if (!ack_r) begin
                beat_addr_r <= start_addr;
                dat_r_r     <= mem[start_addr];
            end else begin
                if (i_wb.we) begin
                    for (int i = 0; i < WB_DATA_SIZE; i++) begin
                        if (i_wb.sel[i]) begin
                            mem[beat_addr_r][i*8 +: 8] <= i_wb.dat_w[i*8 +: 8];
                        end
                    end
                end
                if (burst_more) begin
                    beat_addr_r <= next_addr;
                    dat_r_r     <= mem[next_addr];
                end
            end
        end
    end

    assign i_wb.ack   = ack_r;
    assign i_wb.dat_r = dat_r_r;

endmodule

/* design/procyon_biu_controller_wb.sv */
//////////////////////////////
// Wishbone bus master for BIU requests
// Master only, no error or retry
// Read/write use incrementing bursts,
// RMW uses classic cycles per word
// Addresses assumed word aligned
//////////////////////////////

module procyon_biu_controller_wb #(
    parameter OPTN_BIU_DATA_SIZE = 16,
    parameter OPTN_WB_DATA_WIDTH = 16,
    parameter OPTN_ADDR_WIDTH    = 32
)(
    input  logic                    i_wb_clk,
    input  logic                    i_rst,
    procyon_biu_req_if.controller   i_req,
    procyon_wb_if.master            o_wb
);

    localparam BIU_DATA_WIDTH = OPTN_BIU_DATA_SIZE * 8;
    localparam WB_DATA_SIZE   = OPTN_WB_DATA_WIDTH / 8;
    localparam LINE_WORDS     = BIU_DATA_WIDTH / OPTN_WB_DATA_WIDTH;
    localparam IDX_WIDTH      = LINE_WORDS > 1 ? $clog2(LINE_WORDS) : 1;
    localparam CNT_WIDTH      = $clog2(procyon_biu_pkg::BIU_LEN_MAX_SIZE / WB_DATA_SIZE) + 1;

    typedef enum logic [2:0] {
        IDLE       = 3'b000,
        SEND_REQ   = 3'b001,
        RMW_READ   = 3'b010,
        RMW_MODIFY = 3'b011,
        RMW_WRITE  = 3'b100,
        DONE       = 3'b101
    } state_e;

    state_e                        state_r;
    logic [CNT_WIDTH-1:0]          init_cnt;
    logic [CNT_WIDTH-1:0]          cnt_r;
    logic                          last_beat;
    logic [IDX_WIDTH-1:0]          idx_r;
    logic [IDX_WIDTH-1:0]          idx_nxt;
    logic                          done_r;
    logic [BIU_DATA_WIDTH-1:0]     biu_data_r;
    logic [WB_DATA_SIZE-1:0]       rmw_sel;
    logic [OPTN_WB_DATA_WIDTH-1:0] rmw_old;
    logic [OPTN_WB_DATA_WIDTH-1:0] rmw_new;
    logic [OPTN_WB_DATA_WIDTH-1:0] rmw_data;

    // Beats per request, at least one when the request is narrower than a word
    always_comb begin
        init_cnt = CNT_WIDTH'(procyon_biu_pkg::biu_len_bytes(i_req.len) / WB_DATA_SIZE);
        if (init_cnt == '0) begin
            init_cnt = CNT_WIDTH'(1);
        end
    end

    assign last_beat = (cnt_r == CNT_WIDTH'(1));
    assign idx_nxt   = idx_r + 1'b1;

    // Merge requested bytes over the word that was read
    assign rmw_sel = i_req.sel[idx_r*WB_DATA_SIZE +: WB_DATA_SIZE];
    assign rmw_old = biu_data_r[idx_r*OPTN_WB_DATA_WIDTH +: OPTN_WB_DATA_WIDTH];
    assign rmw_new = i_req.wdata[idx_r*OPTN_WB_DATA_WIDTH +: OPTN_WB_DATA_WIDTH];

    always_comb begin
        for (int i = 0; i < WB_DATA_SIZE; i++) begin
            rmw_data[i*8 +: 8] = rmw_sel[i] ? rmw_new[i*8 +: 8] : rmw_old[i*8 +: 8];
        end
    end

    // Control FSM and bus strobes
    always_ff @(posedge i_wb_clk) begin
        if (i_rst) begin
            state_r  <= IDLE;
            o_wb.cyc <= 1'b0;
            o_wb.stb <= 1'b0;
            o_wb.we  <= 1'b0;
            done_r   <= 1'b0;
        end else begin
            case (state_r)
                IDLE: begin
                    if (i_req.en) begin
                        o_wb.cyc <= 1'b1;
                        o_wb.stb <= 1'b1;
                        o_wb.we  <= (i_req.func == procyon_biu_pkg::BIU_FUNC_WRITE);
                        state_r  <= (i_req.func == procyon_biu_pkg::BIU_FUNC_RMW) ?
                                    RMW_READ : SEND_REQ;
                    end
                end
                SEND_REQ: begin
                    if (o_wb.ack && last_beat) begin
                        o_wb.cyc <= 1'b0;
                        o_wb.stb <= 1'b0;
                        o_wb.we  <= 1'b0;
                        done_r   <= 1'b1;
                        state_r  <= DONE;
                    end
                end
                RMW_READ: begin
                    if (o_wb.ack) begin
                        o_wb.stb <= 1'b0;
                        state_r  <= RMW_MODIFY;
                    end
                end
                RMW_MODIFY: begin
                    o_wb.stb <= 1'b1;
                    o_wb.we  <= 1'b1;
                    state_r  <= RMW_WRITE;
                end
                RMW_WRITE: begin
                    if (o_wb.ack) begin
                        o_wb.we <= 1'b0;
                        if (last_beat) begin
                            o_wb.cyc <= 1'b0;
                            o_wb.stb <= 1'b0;
                            done_r   <= 1'b1;
                            state_r  <= DONE;
                        end else begin
                            state_r <= RMW_READ;
                        end
                    end
                end
                DONE: begin
                    done_r  <= 1'b0;
                    state_r <= IDLE;
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    // Address, data and beat bookkeeping, only moves on ack
    always_ff @(posedge i_wb_clk) begin
        case (state_r)
            IDLE: begin
                if (i_req.en) begin
                    if (i_req.func == procyon_biu_pkg::BIU_FUNC_RMW) begin
                        o_wb.cti <= procyon_biu_pkg::WB_CTI_CLASSIC;
                        o_wb.sel <= '1;
                    end else begin
                        o_wb.cti <= (init_cnt == CNT_WIDTH'(1)) ?
                                    procyon_biu_pkg::WB_CTI_END_OF_BURST :
                                    procyon_biu_pkg::WB_CTI_INCREMENTING;
                        o_wb.sel <= i_req.sel[0 +: WB_DATA_SIZE];
                    end
                    o_wb.bte   <= procyon_biu_pkg::WB_BTE_LINEAR;
                    o_wb.addr  <= i_req.addr;
                    o_wb.dat_w <= i_req.wdata[0 +: OPTN_WB_DATA_WIDTH];
                    idx_r      <= '0;
                    cnt_r      <= init_cnt;
                    biu_data_r <= '0;
                end
            end
            SEND_REQ: begin
                if (o_wb.ack) begin
                    if (!o_wb.we) begin
                        biu_data_r[idx_r*OPTN_WB_DATA_WIDTH +: OPTN_WB_DATA_WIDTH] <= o_wb.dat_r;
                    end
                    if (cnt_r == CNT_WIDTH'(2)) begin
                        o_wb.cti <= procyon_biu_pkg::WB_CTI_END_OF_BURST;
                    end
                    o_wb.sel   <= i_req.sel[idx_nxt*WB_DATA_SIZE +: WB_DATA_SIZE];
                    o_wb.dat_w <= i_req.wdata[idx_nxt*OPTN_WB_DATA_WIDTH +: OPTN_WB_DATA_WIDTH];
                    o_wb.addr  <= o_wb.addr + OPTN_ADDR_WIDTH'(WB_DATA_SIZE);
                    idx_r      <= idx_nxt;
                    cnt_r      <= cnt_r - 1'b1;
                end
            end
            RMW_READ: begin
                if (o_wb.ack) begin
                    biu_data_r[idx_r*OPTN_WB_DATA_WIDTH +: OPTN_WB_DATA_WIDTH] <= o_wb.dat_r;
                end
            end
            RMW_MODIFY: o_wb.dat_w <= rmw_data;
            RMW_WRITE: begin
                if (o_wb.ack) begin
                    o_wb.addr <= o_wb.addr + OPTN_ADDR_WIDTH'(WB_DATA_SIZE);
                    idx_r     <= idx_nxt;
                    cnt_r     <= cnt_r - 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign i_req.done  = done_r;
    assign i_req.rdata = biu_data_r;

endmodule

/* design/procyon_biu_arbiter.sv */
//////////////////////////////
// Two port round-robin BIU arbiter
// Grant is held until the bus master
// reports done; p0 wins the first tie
//////////////////////////////

module procyon_biu_arbiter (
    input  logic                    i_wb_clk,
    input  logic                    i_rst,
    procyon_biu_req_if.controller   i_p0,
    procyon_biu_req_if.controller   i_p1,
    procyon_biu_req_if.requester    o_req
);

    logic       busy_r;
    logic [1:0] grant_r;
    logic       last_r;
    logic       grant_sel;
    logic       route_p1;
    logic       owner_p1;

    // Pick a port while free, the other one wins a tie
    always_comb begin
        if (i_p0.en && i_p1.en) begin
            grant_sel = ~last_r;
        end else begin
            grant_sel = i_p1.en;
        end
    end

    assign route_p1 = busy_r ? grant_r[1] : grant_sel;

    always_ff @(posedge i_wb_clk) begin
        if (i_rst) begin
            busy_r  <= 1'b0;
            grant_r <= 2'b00;
            last_r  <= 1'b1;
        end else if (!busy_r && o_req.en) begin
            busy_r  <= 1'b1;
            grant_r <= {grant_sel, ~grant_sel};
        end else if (busy_r && o_req.done) begin
            busy_r  <= 1'b0;
            grant_r <= 2'b00;
            last_r  <= grant_r[1];
        end
    end

    assign o_req.en    = route_p1 ? i_p1.en    : i_p0.en;
    assign o_req.func  = route_p1 ? i_p1.func  : i_p0.func;
    assign o_req.len   = route_p1 ? i_p1.len   : i_p0.len;
    assign o_req.sel   = route_p1 ? i_p1.sel   : i_p0.sel;
    assign o_req.addr  = route_p1 ? i_p1.addr  : i_p0.addr;
    assign o_req.wdata = route_p1 ? i_p1.wdata : i_p0.wdata;

    // Response stays with the last served port until the next grant
    assign owner_p1 = busy_r ? grant_r[1] : last_r;

    assign i_p0.done  = o_req.done & grant_r[0];
    assign i_p1.done  = o_req.done & grant_r[1];
    assign i_p0.rdata = owner_p1 ? '0 : o_req.rdata;
    assign i_p1.rdata = owner_p1 ? o_req.rdata : '0;

endmodule

/* design/procyon_wb_if.sv */
//////////////////////////////
// Wishbone B4 master/slave bundle
// Registered feedback, linear bursts only
//////////////////////////////

interface procyon_wb_if #(
    parameter OPTN_WB_DATA_WIDTH = 16,
    parameter OPTN_ADDR_WIDTH    = 32
);

    localparam WB_DATA_SIZE = OPTN_WB_DATA_WIDTH / 8;

    logic                            cyc;
    logic                            stb;
    logic                            we;
    procyon_biu_pkg::wb_cti_e        cti;
    logic [1:0]                      bte;
    logic [WB_DATA_SIZE-1:0]         sel;
    logic [OPTN_ADDR_WIDTH-1:0]      addr;
    logic [OPTN_WB_DATA_WIDTH-1:0]   dat_w;
    logic                            ack;
    logic [OPTN_WB_DATA_WIDTH-1:0]   dat_r;

    modport master (output cyc, stb, we, cti, bte, sel, addr, dat_w, input ack, dat_r);
    modport slave (input cyc, stb, we, cti, bte, sel, addr, dat_w, output ack, dat_r);

endinterface

/* design/procyon_biu_req_if.sv */
//////////////////////////////
// One BIU request and its response
// Fields must stay stable until done
// done is a single cycle pulse
//////////////////////////////

interface procyon_biu_req_if #(
    parameter OPTN_BIU_DATA_SIZE = 16,
    parameter OPTN_ADDR_WIDTH    = 32
);

    localparam BIU_DATA_WIDTH = OPTN_BIU_DATA_SIZE * 8;

    logic                            en;
    procyon_biu_pkg::biu_func_e      func;
    procyon_biu_pkg::biu_len_e       len;
    logic [OPTN_BIU_DATA_SIZE-1:0]   sel;
    logic [OPTN_ADDR_WIDTH-1:0]      addr;
    logic [BIU_DATA_WIDTH-1:0]       wdata;
    logic                            done;
    logic [BIU_DATA_WIDTH-1:0]       rdata;

    modport requester (output en, func, len, sel, addr, wdata, input done, rdata);
    modport controller (input en, func, len, sel, addr, wdata, output done, rdata);

endinterface

/* design/procyon_biu_pkg.sv */
//////////////////////////////
// Shared BIU request and Wishbone encodings
// A request is at most one 16 byte line
// Only the linear burst type is defined
//////////////////////////////

package procyon_biu_pkg;

    typedef enum logic [1:0] {
        BIU_FUNC_READ  = 2'b00,
        BIU_FUNC_WRITE = 2'b01,
        BIU_FUNC_RMW   = 2'b10
    } biu_func_e;

    // Encoded as log2 of the byte count
    typedef enum logic [2:0] {
        BIU_LEN_1B  = 3'b000,
        BIU_LEN_2B  = 3'b001,
        BIU_LEN_4B  = 3'b010,
        BIU_LEN_8B  = 3'b011,
        BIU_LEN_16B = 3'b100
    } biu_len_e;

    // Wishbone B4 cycle type identifiers
    typedef enum logic [2:0] {
        WB_CTI_CLASSIC      = 3'b000,
        WB_CTI_INCREMENTING = 3'b010,
        WB_CTI_END_OF_BURST = 3'b111
    } wb_cti_e;

    localparam logic [1:0] WB_BTE_LINEAR = 2'b00;
    localparam int BIU_LEN_MAX_SIZE = 16;

    function automatic int unsigned biu_len_bytes(biu_len_e len);
        return int'(1) << len;
    endfunction

endpackage
